// ==== include/fir_defines.svh ====
// FIR filter sizing constants
// widths, tap counts, adder tree depth and pipeline latency

`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// sample and internal datapath width, all arithmetic wraps at this width
`define FIR_DW 18

// full symmetric filter length
`define FIR_NUM_TAPS 43

// unique coefficients after folding, ceil(taps / 2)
`define FIR_NUM_UNIQ 22

// registered adder levels for 22 products
`define FIR_TREE_LEVELS 5

// enabled edges from sample capture to output
// delay line 1, pre-adder 1, multiplier 1, adder tree 5
`define FIR_LATENCY 8

`endif

// ==== rtl/fir_pkg.sv ====
// FIR filter shared types
// sample vectors for the datapath and the fixed symmetric coefficient set

`include "fir_defines.svh"

package fir_pkg;

	// one signed sample or partial sum
	typedef logic signed [`FIR_DW-1:0] sample_t;

	// whole delay line, entry 0 is the newest sample
	typedef sample_t [`FIR_NUM_TAPS-1:0] tap_vec_t;

	// folded sums or products, one per unique coefficient
	typedef sample_t [`FIR_NUM_UNIQ-1:0] fold_vec_t;

	// ************************************************************
	// coefficients 0..21, tap k uses entry min(k, 42-k)
	// ************************************************************
	localparam sample_t coef_table [`FIR_NUM_UNIQ] = '{
		18'sd88,
		18'sd0,
		-18'sd97,
		-18'sd197,
		-18'sd294,
		-18'sd380,
		-18'sd447,
		-18'sd490,
		-18'sd504,
		-18'sd481,
		-18'sd420,
		-18'sd319,
		-18'sd178,
		18'sd0,
		18'sd212,
		18'sd451,
		18'sd710,
		18'sd980,
		18'sd1252,
		18'sd1514,
		18'sd1756,
		18'sd1971
	};

endpackage

// ==== rtl/fir_delay_line.sv ====
// FIR sample delay line
// 43-deep shift register, advances on every enabled edge

`timescale 1ns/100ps

`include "fir_defines.svh"

module fir_delay_line (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_clk_ena,
	input  fir_pkg::sample_t   i_sample,
	output fir_pkg::tap_vec_t  o_taps
);

	fir_pkg::tap_vec_t taps_q;

	// new sample enters at tap 0, oldest falls off tap 42
	// invalid samples are shifted in too, they stay in the history
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			taps_q <= '0;
		end else if (i_clk_ena) begin
			taps_q <= {taps_q[`FIR_NUM_TAPS-2:0], i_sample};
		end
	end

	assign o_taps = taps_q;

endmodule

// ==== rtl/fir_preadd.sv ====
// FIR symmetric pre-adder
// folds tap pairs k and 42-k into one registered sum each,
// the centre tap passes through a bye register

`timescale 1ns/100ps

`include "fir_defines.svh"

module fir_preadd (
	input  logic                clk,
	input  logic                reset,
	input  logic                i_clk_ena,
	input  fir_pkg::tap_vec_t   i_taps,
	output fir_pkg::fold_vec_t  o_folded
);

	fir_pkg::fold_vec_t folded_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			folded_q <= '0;
		end else if (i_clk_ena) begin
			// pairs share a coefficient, sum wraps at 18 bits
			for (int k = 0; k < `FIR_NUM_UNIQ - 1; k++) begin
				folded_q[k] <= i_taps[k] + i_taps[`FIR_NUM_TAPS-1-k];
			end
			// centre tap has no partner
			folded_q[`FIR_NUM_UNIQ-1] <= i_taps[`FIR_NUM_UNIQ-1];
		end
	end

	assign o_folded = folded_q;

endmodule

// ==== rtl/fir_coef_mult.sv ====
// FIR coefficient multipliers
// one registered product per folded sum, low 18 bits kept

`timescale 1ns/100ps

`include "fir_defines.svh"

module fir_coef_mult (
	input  logic                clk,
	input  logic                reset,
	input  logic                i_clk_ena,
	input  fir_pkg::fold_vec_t  i_folded,
	output fir_pkg::fold_vec_t  o_products
);

	fir_pkg::fold_vec_t products_q;

	// product is sized to the 18-bit target, upper half dropped
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			products_q <= '0;
		end else if (i_clk_ena) begin
			for (int k = 0; k < `FIR_NUM_UNIQ; k++) begin
				products_q[k] <= i_folded[k] * fir_pkg::coef_table[k];
			end
		end
	end

	assign o_products = products_q;

endmodule

// ==== rtl/fir_adder_tree.sv ====
// FIR output adder tree
// five registered levels of pairwise sums, 22 -> 11 -> 6 -> 3 -> 2 -> 1,
// an odd last entry goes through a bye register to keep paths aligned

`timescale 1ns/100ps

`include "fir_defines.svh"

module fir_adder_tree (
	input  logic                clk,
	input  logic                reset,
	input  logic                i_clk_ena,
	input  fir_pkg::fold_vec_t  i_products,
	output fir_pkg::sample_t    o_sum
);

	// entries present at the input of a level
	function automatic int level_count(input int lvl);
		int n;
		n = `FIR_NUM_UNIQ;
		for (int i = 0; i < lvl; i++) begin
			n = (n + 1) / 2;
		end
		return n;
	endfunction

	// ************************************************************
	// one generate block per tree level
	// ************************************************************
	genvar l, j;

	for (l = 0; l < `FIR_TREE_LEVELS; l++) begin : g_level
		localparam int N_IN  = level_count(l);
		localparam int N_OUT = level_count(l + 1);

		fir_pkg::sample_t src [N_IN];
		fir_pkg::sample_t sum_q [N_OUT];

		// first level reads the products, others the level before
		if (l == 0) begin : g_src
			for (j = 0; j < N_IN; j++) begin : g_in
				assign src[j] = i_products[j];
			end
		end else begin : g_src
			for (j = 0; j < N_IN; j++) begin : g_in
				assign src[j] = g_level[l-1].sum_q[j];
			end
		end

		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				sum_q <= '{default: '0};
			end else if (i_clk_ena) begin
				for (int k = 0; k < N_IN / 2; k++) begin
					sum_q[k] <= src[2*k] + src[2*k+1];
				end
				// bye register for the odd one out
				if (N_IN % 2 == 1) begin
					sum_q[N_OUT-1] <= src[N_IN-1];
				end
			end
		end
	end

	assign o_sum = g_level[`FIR_TREE_LEVELS-1].sum_q[0];

endmodule

// ==== rtl/fir_valid_pipe.sv ====
// FIR valid delay line
// shifts the input valid flag along with the datapath latency

`timescale 1ns/100ps

`include "fir_defines.svh"

module fir_valid_pipe (
	input  logic clk,
	input  logic reset,
	input  logic i_clk_ena,
	input  logic i_valid,
	output logic o_valid
);

	logic [`FIR_LATENCY-1:0] valid_q;

	// same enable as the datapath so stalls keep them aligned
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= '0;
		end else if (i_clk_ena) begin
			valid_q <= {valid_q[`FIR_LATENCY-2:0], i_valid};
		end
	end

	assign o_valid = valid_q[`FIR_LATENCY-1];

endmodule

// ==== rtl/fir_top.sv ====
// 43-tap symmetric FIR filter, top level
// delay line, pre-adder, multipliers and adder tree, with a matched valid pipe

`timescale 1ns/100ps

`include "fir_defines.svh"

module fir_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              i_clk_ena,
	input  logic              i_valid,
	input  fir_pkg::sample_t  i_sample,
	output logic              o_valid,
	output fir_pkg::sample_t  o_sample
);

	fir_pkg::tap_vec_t  taps;
	fir_pkg::fold_vec_t folded;
	fir_pkg::fold_vec_t products;

	// ************************************************************
	// datapath
	// ************************************************************
	fir_delay_line delay_line_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_sample  (i_sample),
		.o_taps    (taps)
	);

	fir_preadd preadd_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_taps    (taps),
		.o_folded  (folded)
	);

	fir_coef_mult coef_mult_i (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_folded   (folded),
		.o_products (products)
	);

	fir_adder_tree adder_tree_i (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.o_sum      (o_sample)
	);

	// output valid marker
	fir_valid_pipe valid_pipe_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.o_valid   (o_valid)
	);

endmodule

// ==== dv/fir_props.sv ====
// FIR top level assertions
// reset state, valid latency under clock enable, and stall hold

`timescale 1ns/100ps

`include "fir_defines.svh"

module fir_props (
	input logic             clk,
	input logic             reset,
	input logic             i_clk_ena,
	input logic             i_valid,
	input logic             o_valid,
	input fir_pkg::sample_t o_sample
);

	// i_valid history counted in enabled edges
	logic [`FIR_LATENCY-1:0] valid_hist;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_hist <= '0;
		end else if (i_clk_ena) begin
			valid_hist <= {valid_hist[`FIR_LATENCY-2:0], i_valid};
		end
	end

	a_reset_valid_low : assert property (@(posedge clk) reset |-> !o_valid)
		else $error("o_valid high during reset");

	a_valid_latency : assert property (@(posedge clk) disable iff (reset)
		o_valid == valid_hist[`FIR_LATENCY-1])
		else $error("o_valid not aligned with delayed i_valid");

	a_stall_hold : assert property (@(posedge clk) disable iff (reset)
		!i_clk_ena |=> $stable(o_sample) && $stable(o_valid))
		else $error("outputs changed while clock enable low");

endmodule

bind fir_top fir_props props_i (
	.clk       (clk),
	.reset     (reset),
	.i_clk_ena (i_clk_ena),
	.i_valid   (i_valid),
	.o_valid   (o_valid),
	.o_sample  (o_sample)
);

// ==== dv/fir_tb.sv ====
// FIR filter testbench
// impulse, random, valid gaps, clock enable stalls and mid-stream reset,
// checked against a direct convolution model of the 43-tap filter

`timescale 1ns/100ps

`include "fir_defines.svh"

module fir_tb;

	localparam int RESET_CYCLES = 16;
	localparam int N_IMP        = 51;
	localparam int N_RAND       = 200;
	localparam int N_GAP        = 200;
	localparam int N_STALL      = 150;
	localparam int MAX_STALL    = 3;
	localparam int N_PRE        = 20;
	localparam int N_POST       = 60;
	localparam int DRAIN_MAX    = `FIR_LATENCY + 6;

	// worst case stimulus length including five drains
	localparam int STIM_CYCLES = 2 * RESET_CYCLES + N_IMP + N_RAND + N_GAP
		+ N_STALL * (MAX_STALL + 1) + N_PRE + 1 + N_POST + 5 * (DRAIN_MAX + 4);
	localparam int TIMEOUT_CYCLES = STIM_CYCLES + 200;

	logic             clk;
	logic             reset;
	logic             i_clk_ena;
	logic             i_valid;
	fir_pkg::sample_t i_sample;
	logic             o_valid;
	fir_pkg::sample_t o_sample;

	fir_pkg::sample_t history [`FIR_NUM_TAPS];
	fir_pkg::sample_t exp_q [$];
	fir_pkg::sample_t exp_val;
	logic             edge_ena;
	logic [31:0]      rng;
	int               check_errors = 0;
	int               flow_errors = 0;
	int               cycle_count = 0;

	fir_top dut_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_sample  (i_sample),
		.o_valid   (o_valid),
		.o_sample  (o_sample)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ************************************************************
	// reference model
	// ************************************************************
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// plain convolution with tap k weighted by entry min(k, 42-k)
	function automatic fir_pkg::sample_t fir_ref(input fir_pkg::sample_t h [`FIR_NUM_TAPS]);
		longint acc;
		int     c;
		acc = 0;
		for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
			c = (k < `FIR_NUM_TAPS - 1 - k) ? k : `FIR_NUM_TAPS - 1 - k;
			acc += longint'(fir_pkg::coef_table[c]) * longint'(h[k]);
		end
		return acc[`FIR_DW-1:0];
	endfunction

	// history advances on enabled edges only and keeps invalid samples
	always @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
				history[k] = '0;
			end
			exp_q.delete();
			edge_ena = 1'b0;
		end else begin
			edge_ena = i_clk_ena;
			if (i_clk_ena) begin
				for (int k = `FIR_NUM_TAPS - 1; k > 0; k--) begin
					history[k] = history[k-1];
				end
				history[0] = i_sample;
				if (i_valid) begin
					exp_q.push_back(fir_ref(history));
				end
			end
		end
	end

	task automatic check_value(input logic signed [31:0] got, input logic signed [31:0] exp,
		input string what);
		if (got !== exp) begin
			check_errors++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// outputs sampled mid-cycle after each enabled edge
	always @(negedge clk) begin
		if (reset) begin
			check_value(32'(o_valid), 32'sd0, "o_valid during reset");
		end else if (edge_ena && o_valid) begin
			if (exp_q.size() == 0) begin
				flow_errors++;
				$display("error at %0t: o_valid high with no result expected", $time);
			end else begin
				exp_val = exp_q.pop_front();
				check_value(32'(o_sample), 32'(exp_val), "o_sample");
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ************************************************************
	// stimulus
	// ************************************************************
	// optional stall cycles carry junk that must be ignored
	task automatic send_sample(input fir_pkg::sample_t s, input logic v, input int stalls);
		for (int i = 0; i < stalls; i++) begin
			@(posedge clk);
			rng = xorshift32(rng);
			i_clk_ena <= 1'b0;
			i_sample  <= rng[17:0];
			i_valid   <= rng[20];
		end
		@(posedge clk);
		i_clk_ena <= 1'b1;
		i_sample  <= s;
		i_valid   <= v;
	endtask

	// bounded wait for the results still in flight
	task automatic drain_pipeline();
		int n;
		n = 0;
		repeat (2) send_sample('0, 1'b0, 0);
		while (exp_q.size() != 0 && n < DRAIN_MAX) begin
			send_sample('0, 1'b0, 0);
			n++;
		end
		repeat (2) send_sample('0, 1'b0, 0);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset     <= 1'b1;
		i_clk_ena <= 1'b0;
		i_valid   <= 1'b0;
		i_sample  <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	endtask

	initial begin
		reset     = 1'b1;
		i_clk_ena = 1'b0;
		i_valid   = 1'b0;
		i_sample  = '0;
		rng       = 32'd39;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		// impulse gives the coefficients back in tap order
		send_sample(18'sd1, 1'b1, 0);
		for (int i = 1; i < N_IMP; i++) begin
			send_sample('0, 1'b1, 0);
		end
		drain_pipeline();

		// full-scale random, continuous valid
		for (int i = 0; i < N_RAND; i++) begin
			rng = xorshift32(rng);
			send_sample(rng[17:0], 1'b1, 0);
		end
		drain_pipeline();

		// about a quarter of the samples marked invalid
		for (int i = 0; i < N_GAP; i++) begin
			rng = xorshift32(rng);
			send_sample(rng[17:0], rng[21:20] != 2'b00, 0);
		end
		drain_pipeline();

		// up to MAX_STALL disabled cycles before each sample
		for (int i = 0; i < N_STALL; i++) begin
			rng = xorshift32(rng);
			send_sample(rng[17:0], rng[24], int'(rng[31:30]));
		end
		drain_pipeline();

		// reset with results still in flight
		for (int i = 0; i < N_PRE; i++) begin
			rng = xorshift32(rng);
			send_sample(rng[17:0], 1'b1, 0);
		end
		apply_reset();
		for (int i = 0; i < N_POST; i++) begin
			rng = xorshift32(rng);
			send_sample(rng[17:0], 1'b1, 0);
		end
		drain_pipeline();

		if (exp_q.size() != 0) begin
			flow_errors++;
			$display("error: %0d expected results never came out", exp_q.size());
		end
		$display("summary: %0d value mismatches, %0d flow errors", check_errors, flow_errors);
		if (check_errors == 0 && flow_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+include
rtl/fir_pkg.sv
rtl/fir_delay_line.sv
rtl/fir_preadd.sv
rtl/fir_coef_mult.sv
rtl/fir_adder_tree.sv
rtl/fir_valid_pipe.sv
rtl/fir_top.sv
dv/fir_props.sv
dv/fir_tb.sv

// ==== Makefile ====
TOOL     = verilator
TOP      = fir_tb
FILELIST = filelist.f
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
